// ==== verilog.f ====
common/fpcast_pkg.sv
cast/cast_normalize.sv
cast/cast_stage_reg.sv
cast/cast_round.sv
verilog/fpcast_top.sv
testbench/fpcast_asserts.sv
testbench/tb_fpcast.sv

// ==== Makefile ====
# Verilator flow for the binary32 <-> int32 cast unit
TOP := tb_fpcast

.PHONY: all lint build sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --assert -f verilog.f --top-module $(TOP)

build:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP)

# a crashed or aborted run counts as a failure too
sim: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "*** FAILED ***" >> sim.log
	cat sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then echo "sim: FAIL"; exit 1; fi
	@echo "sim: PASS"

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_fpcast.sv ====
//----------------------------------------------------------
// random and directed checks of fpcast_top against a model
// the model uses 64-bit integer math only
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_fpcast
  import fpcast_pkg::*;
();

  localparam int WAIT_LIMIT = 1000;  // cycles allowed per wait loop

  // zero, inf, nan, subnormal, .5 ties, int range limits
  localparam logic [31:0] EDGE_WORDS [0:21] = '{
    32'h0000_0000, 32'h8000_0000, 32'h7F80_0000, 32'hFF80_0000, 32'h7FC0_0000,
    32'h7F80_0001, 32'h0000_0001, 32'h8000_0001, 32'h007F_FFFF, 32'h3F00_0000,
    32'hBF00_0000, 32'h3FC0_0000, 32'h4020_0000, 32'hC020_0000, 32'h4F00_0000,
    32'hCF00_0000, 32'h4F80_0000, 32'h4F7F_FFFF, 32'h3EFF_FFFF, 32'hFFFF_FFFF,
    32'h0100_0001, 32'h0200_0006
  };

  logic       clk = 1'b0;
  logic       rst_n;
  logic       in_valid;
  logic       in_ready;
  cast_req_t  req;
  logic       out_valid;
  logic       out_ready = 1'b1;
  cast_resp_t resp;

  bit         bp_mode;      // random out_ready when set
  bit         lat_mode;     // latency checked on each output
  bit         timed_out;
  int         cycle;
  int         checks;
  int         errors;
  int         tests;
  cast_resp_t exp_q[$];     // expected responses, oldest first
  int         acc_q[$];     // acceptance cycle of each item
  int         out_cycles[$];

  fpcast_top DUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .req_i       (req),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .resp_o      (resp)
  );

  always #5 clk = ~clk;

  // stall about one cycle in four
  always @(posedge clk) begin
    out_ready <= bp_mode ? ($urandom_range(3) != 0) : 1'b1;
  end

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  function automatic bit round_decision(roundmode_e mode, bit sign, logic [63:0] keep,
                                        logic [63:0] rem, logic [63:0] half);
    if (rem == 0) return 1'b0;  // exact
    case (mode)
      RNE:     return (rem > half) || ((rem == half) && keep[0]);
      RDN:     return sign;
      RUP:     return !sign;
      RMM:     return rem >= half;
      default: return 1'b0;
    endcase
  endfunction

  function automatic cast_resp_t model_i2f(cast_req_t r);
    cast_resp_t  res;
    logic [31:0] v;
    bit          sign;
    logic [63:0] mag;
    logic [63:0] keep;
    logic [63:0] rem;
    logic [63:0] half;
    int          p;
    int          sh;
    v    = r.operand.ival;
    res  = '0;
    sign = v[31] && !r.is_unsigned;
    mag  = {32'h0, sign ? (32'h0 - v) : v};
    if (mag == 0) return res;  // +0, no flags
    p = 0;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) p = i;
    end
    rem  = 0;
    half = 0;
    if (p <= 23) begin
      keep = mag << (23 - p);
    end else begin
      sh   = p - 23;
      keep = mag >> sh;
      rem  = mag & ((64'd1 << sh) - 1);
      half = 64'd1 << (sh - 1);
    end
    keep = keep + 64'(round_decision(r.rnd_mode, sign, keep, rem, half));
    if (keep[24]) begin  // carry into next binade
      keep = keep >> 1;
      p++;
    end
    res.result    = {sign, 8'(p + 127), keep[22:0]};
    res.status.NX = (rem != 0);
    return res;
  endfunction

  function automatic cast_resp_t model_f2i(cast_req_t r);
    cast_resp_t  res;
    bit          s;
    bit          ovf;
    int          e;
    int          sh;
    int          n;
    logic [22:0] f;
    logic [63:0] m;
    logic [63:0] mag;
    logic [63:0] rem;
    logic [63:0] half;
    s   = r.operand.ival[31];
    e   = r.operand.ival[30:23];
    f   = r.operand.ival[22:0];
    res = '0;
    res.status.NV = 1'b1;  // dropped again for regular results
    if (e == 255 && f != 0) begin
      res.result = r.is_unsigned ? 32'hFFFF_FFFF : 32'h7FFF_FFFF;
      return res;
    end
    m    = {40'h0, (e != 0), f};
    sh   = ((e == 0) ? 1 : e) - 150;  // value = m * 2^sh
    rem  = 0;
    half = 0;
    ovf  = (e == 255) || (sh >= 9);
    if (sh >= 0) begin
      mag = m << ((sh > 9) ? 9 : sh);
    end else begin
      n    = (-sh > 60) ? 60 : -sh;  // far below 0.5 anyway
      mag  = m >> n;
      rem  = m & ((64'd1 << n) - 1);
      half = 64'd1 << (n - 1);
    end
    mag = mag + 64'(round_decision(r.rnd_mode, s, mag, rem, half));
    if (!s) begin
      ovf |= (mag > (r.is_unsigned ? 64'hFFFF_FFFF : 64'h7FFF_FFFF));
    end else if (!r.is_unsigned) begin
      ovf |= (mag > 64'h8000_0000);
    end else begin
      ovf |= (mag != 0);  // negative into unsigned
    end
    if (ovf) begin
      if (!s) res.result = r.is_unsigned ? 32'hFFFF_FFFF : 32'h7FFF_FFFF;
      else    res.result = r.is_unsigned ? 32'h0 : 32'h8000_0000;
      return res;
    end
    res.status.NV = 1'b0;
    res.result    = s ? 32'(64'h0 - mag) : mag[31:0];
    res.status.NX = (rem != 0);
    return res;
  endfunction

  function automatic cast_resp_t model_cast(cast_req_t r);
    return (r.op == I2F) ? model_i2f(r) : model_f2i(r);
  endfunction

  // ----------------------------------------------------------
  // output monitor and scoreboard
  // ----------------------------------------------------------
  always @(posedge clk) begin
    cast_resp_t exp_resp;
    int         acc_cycle;
    cycle++;
    if (rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("error at %0t: a response was taken with no request outstanding", $time);
        errors++;
      end else begin
        exp_resp  = exp_q.pop_front();
        acc_cycle = acc_q.pop_front();
        checks++;
        if (resp.result !== exp_resp.result) begin
          $display("[FAIL] %0t resp_o.result expected %08h got %08h", $time,
                   exp_resp.result, resp.result);
          errors++;
        end
        if (resp.status !== exp_resp.status) begin
          $display("[FAIL] %0t resp_o.status expected %05b got %05b", $time,
                   exp_resp.status, resp.status);
          errors++;
        end
        if (lat_mode) begin
          out_cycles.push_back(cycle);
          if (cycle - acc_cycle != 2) begin
            $display("[FAIL] %0t out_valid_o latency expected 2 got %0d", $time,
                     cycle - acc_cycle);
            errors++;
          end
        end
      end
    end
    // push after pop, an item never leaves on its own edge
    if (rst_n && in_valid && in_ready) begin
      exp_q.push_back(model_cast(req));
      acc_q.push_back(cycle);
    end
  end

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------
  function automatic cast_req_t make_req(operation_e op, bit uns, roundmode_e mode,
                                         logic [31:0] word);
    cast_req_t r;
    r.operand.ival = word;
    r.op           = op;
    r.is_unsigned  = uns;
    r.rnd_mode     = mode;
    return r;
  endfunction

  function automatic logic [31:0] random_float();
    logic [31:0] w;
    w = $urandom();
    case ($urandom_range(3))
      0:       w[30:23] = 8'($urandom_range(160, 110));  // int range and ties
      1:       w[30:23] = 8'($urandom_range(127, 120));  // near 0.5 and 1.0
      2:       w[30:23] = 8'($urandom_range(158, 150));  // near the int limits
      default: w = w;                                     // any, specials too
    endcase
    return w;
  endfunction

  function automatic logic [31:0] random_int();
    logic [31:0] w;
    w = $urandom();
    if ($urandom_range(1) == 0) w = w >> $urandom_range(31);  // small magnitudes
    return w;
  endfunction

  function automatic cast_req_t random_req(operation_e op);
    return make_req(op, bit'($urandom_range(1)), roundmode_e'($urandom_range(4)),
                    (op == I2F) ? random_int() : random_float());
  endfunction

  // holds the request until it is accepted
  task automatic send_req(input cast_req_t r);
    int waited;
    bit accepted;
    if (timed_out) return;
    in_valid <= 1'b1;
    req      <= r;
    waited   = 0;
    accepted = 1'b0;
    while (!accepted && waited < WAIT_LIMIT) begin
      @(posedge clk);
      accepted = in_ready;
      waited++;
    end
    if (!accepted) begin
      $display("timeout: a request was not accepted within %0d cycles", WAIT_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  task automatic drain();
    int waited;
    in_valid <= 1'b0;
    waited = 0;
    // at least one edge so the last accepted item is queued
    do begin
      @(posedge clk);
      waited++;
    end while (!timed_out && exp_q.size() != 0 && waited < WAIT_LIMIT);
    if (exp_q.size() != 0 && !timed_out) begin
      $display("timeout: %0d responses still missing after %0d cycles", exp_q.size(),
               WAIT_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int c0, input int e0);
    tests++;
    $display("test %-12s %0d checks, %0d errors", name, checks - c0, errors - e0);
  endtask

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin
    int c0;
    int e0;
    void'($urandom(32'h61011292));
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    req       = '0;
    bp_mode   = 1'b0;
    lat_mode  = 1'b0;
    timed_out = 1'b0;

    // reset, 5 cycles low then idle
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      if (i == 4) rst_n <= 1'b1;
      if (i > 0) begin
        checks++;
        if (out_valid !== 1'b0) begin
          $display("[FAIL] %0t out_valid_o expected 0 got %b", $time, out_valid);
          errors++;
        end
      end
    end
    report_test("reset", c0, e0);

    // single item, then two back to back
    c0 = checks;
    e0 = errors;
    lat_mode = 1'b1;
    send_req(make_req(I2F, 1'b0, RNE, 32'd12345));
    drain();
    send_req(make_req(F2I, 1'b0, RNE, 32'h4020_0000));
    send_req(make_req(F2I, 1'b1, RUP, 32'h3F40_0000));
    drain();
    lat_mode = 1'b0;
    checks++;
    if (out_cycles.size() != 3) begin
      $display("latency test saw %0d responses instead of 3", out_cycles.size());
      errors++;
    end else if (out_cycles[2] - out_cycles[1] != 1) begin
      $display("[FAIL] %0t out_valid_o gap expected 1 got %0d", $time,
               out_cycles[2] - out_cycles[1]);
      errors++;
    end
    report_test("latency", c0, e0);

    // every edge word both ways, both sign modes, all roundings
    c0 = checks;
    e0 = errors;
    foreach (EDGE_WORDS[w]) begin
      for (int o = 0; o < 2; o++) begin
        for (int u = 0; u < 2; u++) begin
          for (int m = 0; m < 5; m++) begin
            send_req(make_req(operation_e'(o), bit'(u), roundmode_e'(m), EDGE_WORDS[w]));
          end
        end
      end
    end
    drain();
    report_test("directed", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 1500; i++) send_req(random_req(I2F));
    drain();
    report_test("random_i2f", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 1500; i++) send_req(random_req(F2I));
    drain();
    report_test("random_f2i", c0, e0);

    // mixed traffic under random stalls
    c0 = checks;
    e0 = errors;
    bp_mode = 1'b1;
    for (int i = 0; i < 2000; i++) begin
      send_req(random_req(operation_e'($urandom_range(1))));
    end
    drain();
    bp_mode = 1'b0;
    report_test("backpressure", c0, e0);

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== testbench/fpcast_asserts.sv ====
//----------------------------------------------------------
// handshake and reset properties, bound into fpcast_top
//----------------------------------------------------------
`timescale 1ns/1ps

module fpcast_asserts
  import fpcast_pkg::*;
(
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       in_ready_o,
  input logic       out_ready_i,
  input logic       out_valid_o,
  input cast_resp_t resp_o
);

  // every reset edge leaves the output empty
  a_reset_clears_valid: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_o)
    else $error("out_valid_o high in the cycle after reset");

  // stalled output keeps valid and data
  a_hold_under_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(resp_o)))
    else $error("output changed while stalled");

  a_ready_follows: assert property (@(posedge clk_i) in_ready_o == out_ready_i)
    else $error("in_ready_o differs from out_ready_i");

endmodule

bind fpcast_top fpcast_asserts u_asserts (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .in_ready_o  (in_ready_o),
  .out_ready_i (out_ready_i),
  .out_valid_o (out_valid_o),
  .resp_o      (resp_o)
);

// ==== verilog/fpcast_top.sv ====
//----------------------------------------------------------
// binary32 <-> int32 cast unit, two items in flight
// a low out_ready_i stalls every stage
//----------------------------------------------------------
`timescale 1ns/1ps

module fpcast_top
  import fpcast_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  cast_req_t  req_i,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output cast_resp_t resp_o
);

  logic  norm_valid;  // producer -> buffer
  norm_t norm_data;
  norm_t stage_data;  // buffer -> consumer

  assign in_ready_o = out_ready_i;  // whole pipe advances together

  cast_normalize u_normalize (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .advance_i  (out_ready_i),
    .in_valid_i (in_valid_i),
    .req_i      (req_i),
    .valid_o    (norm_valid),
    .norm_o     (norm_data)
  );

  cast_stage_reg u_stage (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .advance_i  (out_ready_i),
    .valid_i    (norm_valid),
    .norm_i     (norm_data),
    .valid_o    (out_valid_o),
    .norm_o     (stage_data)
  );

  cast_round u_round (
    .norm_i (stage_data),
    .resp_o (resp_o)
  );

endmodule

// ==== cast/cast_round.sv ====
//----------------------------------------------------------
// combinational shift, round and result selection
// I2F never overflows, so OF and UF stay low
//----------------------------------------------------------
`timescale 1ns/1ps

module cast_round
  import fpcast_pkg::*;
(
  input  norm_t      norm_i,
  output cast_resp_t resp_o
);

  localparam int unsigned SHAMT_BITS = $clog2(MANT_WIDTH + 2);
  localparam int unsigned FP_DROP    = MANT_WIDTH - FP_MAN_BITS - 1;  // bits below the float lsb

  localparam logic signed [EXP_WIDTH-1:0] BIAS_S     = EXP_WIDTH'(FP_BIAS);
  localparam logic signed [EXP_WIDTH-1:0] INT_TOP_S  = EXP_WIDTH'(INT_WIDTH - 1);
  localparam logic signed [EXP_WIDTH-1:0] HALF_EXP_S = EXP_WIDTH'(-1);  // exponent of 0.5

  logic signed [EXP_WIDTH-1:0] exp_s;
  logic                        is_f2i;

  assign exp_s  = norm_i.exponent;
  assign is_f2i = (norm_i.op == F2I);

  // ----------------------------------------------------------
  // float destination
  // ----------------------------------------------------------
  logic signed [EXP_WIDTH-1:0] fp_biased_exp;
  logic [INT_WIDTH-1:0]        fp_pre_abs;
  logic [1:0]                  fp_rs;  // round, sticky

  assign fp_biased_exp = exp_s + BIAS_S;  // 127..158 for ints
  assign fp_pre_abs    = {1'b0, fp_biased_exp[FP_EXP_BITS-1:0],
                          norm_i.mant[MANT_WIDTH-2 -: FP_MAN_BITS]};  // hidden bit dropped
  assign fp_rs[1]      = norm_i.mant[FP_DROP-1];
  assign fp_rs[0]      = |norm_i.mant[FP_DROP-2:0];

  // ----------------------------------------------------------
  // integer destination
  // ----------------------------------------------------------
  logic signed [EXP_WIDTH-1:0] int_shift_s;
  logic [SHAMT_BITS-1:0]       shamt;
  logic                        of_before;
  logic [2*MANT_WIDTH:0]       preshift;  // mantissa, round slot, sticky field
  logic [2*MANT_WIDTH:0]       dest;
  logic [INT_WIDTH-1:0]        int_pre_abs;
  logic [1:0]                  int_rs;

  assign int_shift_s = INT_TOP_S - exp_s;

  always_comb begin
    shamt     = SHAMT_BITS'(int_shift_s);
    of_before = 1'b0;
    if (exp_s > INT_TOP_S) begin
      shamt     = '0;    // result replaced anyway
      of_before = 1'b1;
    end else if (exp_s < HALF_EXP_S) begin
      shamt = SHAMT_BITS'(MANT_WIDTH + 1);  // everything into sticky
    end
  end

  assign preshift    = {norm_i.mant, {(MANT_WIDTH + 1){1'b0}}};
  assign dest        = preshift >> shamt;
  assign int_pre_abs = dest[2*MANT_WIDTH -: INT_WIDTH];
  assign int_rs[1]   = dest[MANT_WIDTH];
  assign int_rs[0]   = |dest[MANT_WIDTH-1:0];

  // ----------------------------------------------------------
  // rounding, shared by both directions
  // ----------------------------------------------------------
  logic [INT_WIDTH-1:0] pre_abs;
  logic [1:0]           rs;
  logic                 round_up;
  logic [INT_WIDTH:0]   rounded_abs;  // top bit is the int carry

  assign pre_abs = is_f2i ? int_pre_abs : fp_pre_abs;
  assign rs      = is_f2i ? int_rs : fp_rs;

  always_comb begin
    case (norm_i.rnd_mode)
      RNE:     round_up = rs[1] & (rs[0] | pre_abs[0]);  // tie goes to even
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|rs) & norm_i.sign;
      RUP:     round_up = (|rs) & ~norm_i.sign;
      RMM:     round_up = rs[1];
      default: round_up = 1'b0;  // unused encodings truncate
    endcase
  end

  // a float mantissa carry bumps the exponent field
  assign rounded_abs = {1'b0, pre_abs} + (INT_WIDTH + 1)'(round_up);

  // ----------------------------------------------------------
  // integer range and special cases
  // ----------------------------------------------------------
  logic [INT_WIDTH-1:0] rounded_int;
  logic                 rounded_zero;
  logic                 of_after;
  logic [INT_WIDTH-1:0] int_special;
  logic                 int_is_special;

  assign rounded_int  = norm_i.sign ? -rounded_abs[INT_WIDTH-1:0] : rounded_abs[INT_WIDTH-1:0];
  assign rounded_zero = (rounded_abs == '0);

  always_comb begin
    if (norm_i.is_unsigned) begin
      of_after = rounded_abs[INT_WIDTH];
    end else if (norm_i.sign) begin
      // -2^31 still fits
      of_after = rounded_abs[INT_WIDTH] |
                 (rounded_abs[INT_WIDTH-1] & (|rounded_abs[INT_WIDTH-2:0]));
    end else begin
      of_after = rounded_abs[INT_WIDTH] | rounded_abs[INT_WIDTH-1];
    end
  end

  always_comb begin
    int_special = {norm_i.is_unsigned, {(INT_WIDTH - 1){1'b1}}};  // positive max
    if (norm_i.sign && !norm_i.cls.is_nan) begin
      int_special = ~int_special;  // -2^31 or 0
    end
  end

  assign int_is_special = norm_i.cls.is_nan | norm_i.cls.is_inf | of_before | of_after |
                          (norm_i.sign & norm_i.is_unsigned & ~rounded_zero);

  // ----------------------------------------------------------
  // result select
  // ----------------------------------------------------------
  always_comb begin
    resp_o.status = '0;
    if (is_f2i) begin
      if (int_is_special) begin
        resp_o.result    = int_special;
        resp_o.status.NV = 1'b1;  // only NV
      end else begin
        resp_o.result    = rounded_int;
        resp_o.status.NX = |int_rs;
      end
    end else begin
      // int zero gives +0, exact
      resp_o.result    = norm_i.mant_is_zero ? '0 :
                         {norm_i.sign, rounded_abs[INT_WIDTH-2:0]};
      resp_o.status.NX = |fp_rs;
    end
  end

endmodule

// ==== cast/cast_stage_reg.sv ====
//----------------------------------------------------------
// pipeline buffer holding one normalized item
// contents frozen while advance_i is low
//----------------------------------------------------------
`timescale 1ns/1ps

module cast_stage_reg
  import fpcast_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  advance_i,  // output taken or empty slot
  input  logic  valid_i,
  input  norm_t norm_i,
  output logic  valid_o,
  output norm_t norm_o
);

  logic  valid_q;
  norm_t norm_q;   // payload, no reset

  // valid bit, cleared on reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (advance_i) begin
      valid_q <= valid_i;
    end
  end

  // data moves with the valid bit
  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      norm_q <= norm_i;
    end
  end

  assign valid_o = valid_q;
  assign norm_o  = norm_q;

endmodule

// ==== cast/cast_normalize.sv ====
//----------------------------------------------------------
// input register of the cast unit, one item held
// subnormal floats are normalized, ints taken as magnitude
//----------------------------------------------------------
`timescale 1ns/1ps

module cast_normalize
  import fpcast_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      advance_i,   // pipeline moves this cycle
  input  logic      in_valid_i,
  input  cast_req_t req_i,
  output logic      valid_o,
  output norm_t     norm_o
);

  localparam int unsigned LZC_BITS = $clog2(MANT_WIDTH);

  localparam logic signed [EXP_WIDTH-1:0] BIAS_S       = EXP_WIDTH'(FP_BIAS);
  // hidden bit sits at bit 23, the lzc counts from bit 31
  localparam logic signed [EXP_WIDTH-1:0] SHIFT_COMP_S = EXP_WIDTH'(MANT_WIDTH - 1 - FP_MAN_BITS);
  localparam logic signed [EXP_WIDTH-1:0] INT_TOP_S    = EXP_WIDTH'(MANT_WIDTH - 1);

  cast_req_t req_q;    // registered request
  logic      valid_q;

  // ----------------------------------------------------------
  // input register
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (advance_i) begin
      valid_q <= in_valid_i;  // bubble enters when in_valid_i low
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      req_q <= req_i;
    end
  end

  // ----------------------------------------------------------
  // float view
  // ----------------------------------------------------------
  logic      is_i2f;
  logic      exp_zero;
  logic      exp_ones;
  logic      man_zero;
  fp_class_t fp_class;

  assign is_i2f   = (req_q.op == I2F);
  assign exp_zero = (req_q.operand.fp.exponent == '0);
  assign exp_ones = (req_q.operand.fp.exponent == '1);
  assign man_zero = (req_q.operand.fp.mantissa == '0);

  assign fp_class.is_zero      = exp_zero & man_zero;
  assign fp_class.is_subnormal = exp_zero & ~man_zero;
  assign fp_class.is_inf       = exp_ones & man_zero;
  assign fp_class.is_nan       = exp_ones & ~man_zero;
  // quiet bit clear means signalling
  assign fp_class.is_snan      = fp_class.is_nan & ~req_q.operand.fp.mantissa[FP_MAN_BITS-1];

  logic [MANT_WIDTH-1:0] fp_mant;
  assign fp_mant = {{(MANT_WIDTH - FP_MAN_BITS - 1){1'b0}},
                    ~exp_zero,                       // hidden bit
                    req_q.operand.fp.mantissa};

  // ----------------------------------------------------------
  // integer view
  // ----------------------------------------------------------
  logic                  int_sign;
  logic [MANT_WIDTH-1:0] int_mag;

  assign int_sign = req_q.operand.ival[INT_WIDTH-1] & ~req_q.is_unsigned;
  assign int_mag  = int_sign ? -req_q.operand.ival : req_q.operand.ival;  // INT_MIN stays 2^31

  // ----------------------------------------------------------
  // leading zero count and left alignment
  // ----------------------------------------------------------
  logic [MANT_WIDTH-1:0] enc_mant;
  logic [LZC_BITS-1:0]   lzc_cnt;
  logic [MANT_WIDTH-1:0] norm_mant;
  logic                  mant_is_zero;

  assign enc_mant = is_i2f ? int_mag : fp_mant;

  always_comb begin
    lzc_cnt = '0;  // zero input keeps no shift
    for (int i = 0; i < MANT_WIDTH; i++) begin
      if (enc_mant[i]) begin
        lzc_cnt = LZC_BITS'(MANT_WIDTH - 1 - i);  // highest set bit wins
      end
    end
  end

  assign norm_mant    = enc_mant << lzc_cnt;
  assign mant_is_zero = (enc_mant == '0);

  // unbiased exponent
  logic signed [EXP_WIDTH-1:0] biased_exp_s;
  logic signed [EXP_WIDTH-1:0] sub_adj_s;
  logic signed [EXP_WIDTH-1:0] shamt_s;
  logic signed [EXP_WIDTH-1:0] fp_exp_s;
  logic signed [EXP_WIDTH-1:0] int_exp_s;

  assign biased_exp_s = EXP_WIDTH'(req_q.operand.fp.exponent);
  assign sub_adj_s    = EXP_WIDTH'(fp_class.is_subnormal);  // subnormals use exponent 1
  assign shamt_s      = EXP_WIDTH'(lzc_cnt);
  assign fp_exp_s     = biased_exp_s + sub_adj_s - BIAS_S - shamt_s + SHIFT_COMP_S;
  assign int_exp_s    = INT_TOP_S - shamt_s;

  // ----------------------------------------------------------
  // outputs
  // ----------------------------------------------------------
  assign valid_o             = valid_q;
  assign norm_o.sign         = is_i2f ? int_sign : req_q.operand.fp.sign;
  assign norm_o.exponent     = is_i2f ? int_exp_s : fp_exp_s;
  assign norm_o.mant         = norm_mant;
  assign norm_o.mant_is_zero = mant_is_zero;
  assign norm_o.cls          = fp_class;   // don't care for I2F
  assign norm_o.op           = req_q.op;
  assign norm_o.is_unsigned  = req_q.is_unsigned;
  assign norm_o.rnd_mode     = req_q.rnd_mode;

endmodule

// ==== common/fpcast_pkg.sv ====
//----------------------------------------------------------
// types for the binary32 <-> int32 cast unit
// formats are fixed to binary32 and 32-bit integers only
//----------------------------------------------------------
package fpcast_pkg;

  // ----------------------------------------------------------
  // format constants
  // ----------------------------------------------------------
  localparam int unsigned FP_EXP_BITS = 8;
  localparam int unsigned FP_MAN_BITS = 23;
  localparam int unsigned FP_BIAS     = 127;
  localparam int unsigned INT_WIDTH   = 32;

  // internal mantissa holds a whole int or a mantissa with hidden bit
  localparam int unsigned MANT_WIDTH = INT_WIDTH;
  localparam int unsigned EXP_WIDTH  = 10;  // signed, down to -149

  typedef enum logic {
    I2F = 1'b0,
    F2I = 1'b1
  } operation_e;

  typedef enum logic [2:0] {
    RNE = 3'b000,  // nearest, ties to even
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100   // nearest, ties away from zero
  } roundmode_e;

  typedef struct packed {
    logic NV;
    logic DZ;  // never raised here
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  typedef struct packed {
    logic                   sign;
    logic [FP_EXP_BITS-1:0] exponent;  // biased
    logic [FP_MAN_BITS-1:0] mantissa;  // no hidden bit
  } fp32_fields_t;

  // one operand word, decoded by operation
  typedef union packed {
    fp32_fields_t         fp;    // float view
    logic [INT_WIDTH-1:0] ival;  // integer view
  } operand_u;

  typedef struct packed {
    operand_u   operand;
    operation_e op;
    logic       is_unsigned;  // integer side is unsigned
    roundmode_e rnd_mode;
  } cast_req_t;

  typedef struct packed {
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_snan;
    logic is_subnormal;
  } fp_class_t;

  // normalized item between producer and consumer
  typedef struct packed {
    logic                        sign;
    logic signed [EXP_WIDTH-1:0] exponent;      // unbiased
    logic [MANT_WIDTH-1:0]       mant;          // msb set unless zero
    logic                        mant_is_zero;
    fp_class_t                   cls;           // float classification
    operation_e                  op;
    logic                        is_unsigned;
    roundmode_e                  rnd_mode;
  } norm_t;

  typedef struct packed {
    logic [INT_WIDTH-1:0] result;
    status_t              status;
  } cast_resp_t;

endpackage
